/* files.f */
icache_pkg.sv
icache_way.sv
icache_ctrl.sv
icache_fetch_pack.sv
icache_top.sv
icache_mem_model.sv
icache_assertions.sv
tb_icache.sv

/* icache_assertions.sv */
`timescale 1ns/100ps

module icache_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    fetch_ready,
    input logic                    resp_valid,
    input logic                    resp_ready,
    input icache_pkg::fetch_resp_t resp,
    input logic                    mem_req_valid,
    input icache_pkg::mem_req_t    mem_req,
    input logic                    mem_data_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // fetch side
    ////////////////////////////////////////////////////////////////////////////

    resp_held_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp)
    ) else $error("resp changed while resp_ready was low");

    // no new request while the response waits
    ready_low_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |-> !fetch_ready
    ) else $error("fetch_ready high during a stalled response");

    ////////////////////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////////////////////

    mem_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_data_valid |=> mem_req_valid && $stable(mem_req)
    ) else $error("mem request dropped or changed before data arrived");

    mem_quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |=> !mem_req_valid
    ) else $error("mem_req_valid high in the first cycle after reset");

endmodule

bind icache_top icache_assertions handshake_checks (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_ready    (fetch_ready),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp           (resp),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_data_valid (mem_data_valid)
);

/* icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    // fetch side
    input  logic                          fetch_valid,
    input  icache_pkg::fetch_req_t        fetch_req,
    output logic                          fetch_ready,
    input  logic                          flush,
    input  logic                          resp_ready,
    input  logic                          resp_valid,
    // way lookups
    input  icache_pkg::way_lookup_t       lookup0,
    input  icache_pkg::way_lookup_t       lookup1,
    output icache_pkg::index_t            lookup_index,
    output icache_pkg::tag_t              compare_tag,
    // refill write
    output logic [icache_pkg::WAYS-1:0]   wr_en,
    output icache_pkg::index_t            wr_index,
    output icache_pkg::tag_t              wr_tag,
    output icache_pkg::line_t             wr_line,
    output logic                          inv_all,
    // fetch pack control
    output logic                          resp_load,
    output logic                          sel_refill,
    output icache_pkg::offset_t           word_offset,
    output icache_pkg::addr_t             resp_pc,
    output icache_pkg::line_t             refill_line,
    // memory
    input  logic                          mem_data_valid,
    input  icache_pkg::line_t             mem_data,
    output logic                          mem_req_valid,
    output icache_pkg::mem_req_t          mem_req
);
    import icache_pkg::*;

    ctrl_state_t     state;
    ctrl_state_t     state_next;
    addr_t           req_addr;
    index_t          req_index;
    logic            flush_pend;
    logic [SETS-1:0] lru;
    logic            victim;
    logic            any_hit;
    logic            accept;
    logic            refill_done;
    logic            resp_done;

    ////////////////////////////////////////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////////////////////////////////////////

    // no acceptance while an invalidate is due
    always_comb begin
        case (state)
            IDLE:    fetch_ready = !flush && !flush_pend;
            RESPOND: fetch_ready = resp_ready && !flush && !flush_pend;
            default: fetch_ready = 1'b0;
        endcase
    end

    assign accept      = fetch_valid && fetch_ready;
    assign resp_done   = resp_valid && resp_ready;
    assign any_hit     = lookup0.hit || lookup1.hit;
    assign refill_done = (state == REFILL) && mem_data_valid;

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= fetch_req.addr;
        end
    end

    assign req_index = addr_index(req_addr);

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) state_next = LOOKUP;
            end
            LOOKUP: begin
                state_next = any_hit ? RESPOND : REFILL;
            end
            REFILL: begin
                if (mem_data_valid) state_next = RESPOND;
            end
            RESPOND: begin
                // back-to-back hits go straight to the next lookup
                if (accept) begin
                    state_next = LOOKUP;
                end else if (resp_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // line request held until the data pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
        end else if (state == LOOKUP && !any_hit) begin
            mem_req_valid <= 1'b1;
        end else if (mem_data_valid) begin
            mem_req_valid <= 1'b0;
        end
    end

    // flush outside IDLE waits for the next IDLE
    assign inv_all = (state == IDLE) && (flush || flush_pend);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_pend <= 1'b0;
        end else if (inv_all) begin
            flush_pend <= 1'b0;
        end else if (flush) begin
            flush_pend <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lru, one bit per set naming the victim way
    ////////////////////////////////////////////////////////////////////////////

    assign victim = lru[req_index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (state == LOOKUP && any_hit) begin
            // way0 hit makes way1 the victim
            lru[req_index] <= lookup0.hit;
        end else if (refill_done) begin
            lru[req_index] <= !victim;
        end
    end

    // outputs to ways, fetch pack and memory
    assign lookup_index     = addr_index(fetch_req.addr);
    assign compare_tag      = addr_tag(req_addr);
    assign wr_en            = refill_done ? (WAYS'(1) << victim) : '0;
    assign wr_index         = req_index;
    assign wr_tag           = addr_tag(req_addr);
    assign wr_line          = mem_data;
    assign resp_load        = (state == LOOKUP && any_hit) || refill_done;
    assign sel_refill       = (state == REFILL);
    assign word_offset      = addr_offset(req_addr);
    assign resp_pc          = req_addr;
    assign refill_line      = mem_data;
    assign mem_req.line_addr = {req_addr[31:OFFSET_W+2], {(OFFSET_W + 2){1'b0}}};

endmodule

/* icache_fetch_pack.sv */
`timescale 1ns/100ps

module icache_fetch_pack (
    input  logic                    clk,
    input  logic                    rst_n,
    input  icache_pkg::way_lookup_t lookup0,
    input  icache_pkg::way_lookup_t lookup1,
    input  icache_pkg::line_t       refill_line,
    input  logic                    sel_refill,
    input  logic                    resp_load,
    input  icache_pkg::offset_t     word_offset,
    input  icache_pkg::addr_t       resp_pc,
    input  logic                    resp_ready,
    output logic                    resp_valid,
    output icache_pkg::fetch_resp_t resp
);
    import icache_pkg::*;

    line_t       line_sel;
    instr_t      words [LINE_WORDS];
    offset_t     pair_offset;
    fetch_resp_t resp_next;

    // refill data wins, otherwise the hitting way
    always_comb begin
        if (sel_refill) begin
            line_sel = refill_line;
        end else if (lookup1.hit && !lookup0.hit) begin
            line_sel = lookup1.line;
        end else begin
            line_sel = lookup0.line;
        end
    end

    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            words[w] = line_sel[w*32 +: 32];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // word pair
    ////////////////////////////////////////////////////////////////////////////

    // upper word of the aligned 8-byte pair
    assign pair_offset = {word_offset[OFFSET_W-1:1], 1'b1};

    always_comb begin
        resp_next.pc     = resp_pc;
        resp_next.instr0 = words[word_offset];
        if (!word_offset[0]) begin
            resp_next.instr1       = words[pair_offset];
            resp_next.second_valid = 1'b1;
        end else begin
            // odd word has no partner inside the pair
            resp_next.instr1       = '0;
            resp_next.second_valid = 1'b0;
        end
    end

    // response register, held under back-pressure
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (resp_load) begin
            resp_valid <= 1'b1;
        end else if (resp_valid && resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_load) begin
            resp <= resp_next;
        end
    end

endmodule

/* icache_mem_model.sv */
`timescale 1ns/100ps

module icache_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_req_valid,
    input  icache_pkg::mem_req_t mem_req,
    output logic                 mem_data_valid,
    output icache_pkg::line_t    mem_data
);
    import icache_pkg::*;

    integer seed           = 32'h8f36e929;
    int     req_count      = 0;
    addr_t  last_line_addr = '0;
    logic   busy           = 1'b0;
    int     delay          = 0;
    logic   pulse          = 1'b0;
    line_t  line_q         = '0;

    assign mem_data_valid = pulse;
    assign mem_data       = line_q;

    // word at byte address a reads as a ^ 5a5a0000
    function automatic line_t build_line(addr_t base);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*32 +: 32] = (base + w * 4) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    // one request at a time, answered 1 to 8 cycles after it is taken
    always @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            pulse <= 1'b0;
            delay <= 0;
        end else begin
            pulse <= 1'b0;
            if (busy) begin
                if (delay <= 1) begin
                    pulse  <= 1'b1;
                    line_q <= build_line(last_line_addr);
                    busy   <= 1'b0;
                end else begin
                    delay <= delay - 1;
                end
            end else if (mem_req_valid && !pulse) begin
                // request still high during the data pulse, not a new one
                busy           <= 1'b1;
                delay          <= 1 + ($unsigned($random(seed)) % 8);
                req_count      <= req_count + 1;
                last_line_addr <= mem_req.line_addr;
            end
        end
    end

endmodule

/* icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    // 16 sets of 4-word lines
    localparam int INDEX_W    = 4;
    localparam int OFFSET_W   = 2;
    localparam int WAYS       = 2;
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W - 2;
    localparam int LINE_WORDS = 4;
    localparam int SETS       = 1 << INDEX_W;

    typedef logic [31:0]              addr_t;
    typedef logic [31:0]              instr_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [OFFSET_W-1:0]      offset_t;
    // word 0 sits in the low bits
    typedef logic [LINE_WORDS*32-1:0] line_t;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    // instr1 is only meaningful when second_valid is set
    typedef struct packed {
        addr_t  pc;
        instr_t instr0;
        instr_t instr1;
        logic   second_valid;
    } fetch_resp_t;

    // line aligned, low 4 bits always zero
    typedef struct packed {
        addr_t line_addr;
    } mem_req_t;

    typedef struct packed {
        logic  hit;
        line_t line;
    } way_lookup_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        RESPOND
    } ctrl_state_t;

    // address field split
    function automatic offset_t addr_offset(addr_t a);
        return a[OFFSET_W+1:2];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[OFFSET_W+2 +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(addr_t a);
        return a[31 -: TAG_W];
    endfunction

endpackage

/* icache_top.sv */
`timescale 1ns/100ps

module icache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // fetch stage
    input  logic                    fetch_valid,
    input  icache_pkg::fetch_req_t  fetch_req,
    output logic                    fetch_ready,
    output logic                    resp_valid,
    output icache_pkg::fetch_resp_t resp,
    input  logic                    resp_ready,
    input  logic                    flush,
    // memory port
    output logic                    mem_req_valid,
    output icache_pkg::mem_req_t    mem_req,
    input  logic                    mem_data_valid,
    input  icache_pkg::line_t       mem_data
);
    import icache_pkg::*;

    way_lookup_t     lookup0;
    way_lookup_t     lookup1;
    index_t          lookup_index;
    tag_t            compare_tag;
    logic [WAYS-1:0] wr_en;
    index_t          wr_index;
    tag_t            wr_tag;
    line_t           wr_line;
    logic            inv_all;
    logic            resp_load;
    logic            sel_refill;
    offset_t         word_offset;
    addr_t           resp_pc;
    line_t           refill_line;

    ////////////////////////////////////////////////////////////////////////////
    // controller
    ////////////////////////////////////////////////////////////////////////////

    icache_ctrl ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .fetch_ready    (fetch_ready),
        .flush          (flush),
        .resp_ready     (resp_ready),
        .resp_valid     (resp_valid),
        .lookup0        (lookup0),
        .lookup1        (lookup1),
        .lookup_index   (lookup_index),
        .compare_tag    (compare_tag),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_tag         (wr_tag),
        .wr_line        (wr_line),
        .inv_all        (inv_all),
        .resp_load      (resp_load),
        .sel_refill     (sel_refill),
        .word_offset    (word_offset),
        .resp_pc        (resp_pc),
        .refill_line    (refill_line),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req)
    );

    // two ways share index and tag, each has its own write enable
    icache_way way0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .compare_tag  (compare_tag),
        .wr_en        (wr_en[0]),
        .wr_index     (wr_index),
        .wr_tag       (wr_tag),
        .wr_line      (wr_line),
        .inv_all      (inv_all),
        .lookup       (lookup0)
    );

    icache_way way1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_index (lookup_index),
        .compare_tag  (compare_tag),
        .wr_en        (wr_en[1]),
        .wr_index     (wr_index),
        .wr_tag       (wr_tag),
        .wr_line      (wr_line),
        .inv_all      (inv_all),
        .lookup       (lookup1)
    );

    icache_fetch_pack pack (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup0     (lookup0),
        .lookup1     (lookup1),
        .refill_line (refill_line),
        .sel_refill  (sel_refill),
        .resp_load   (resp_load),
        .word_offset (word_offset),
        .resp_pc     (resp_pc),
        .resp_ready  (resp_ready),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

endmodule

/* icache_way.sv */
`timescale 1ns/100ps

module icache_way (
    input  logic                    clk,
    input  logic                    rst_n,
    input  icache_pkg::index_t      lookup_index,
    input  icache_pkg::tag_t        compare_tag,
    input  logic                    wr_en,
    input  icache_pkg::index_t      wr_index,
    input  icache_pkg::tag_t        wr_tag,
    input  icache_pkg::line_t       wr_line,
    input  logic                    inv_all,
    output icache_pkg::way_lookup_t lookup
);
    import icache_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    tag_t            tag_mem  [SETS];
    line_t           line_mem [SETS];
    logic [SETS-1:0] valid;

    // read registers, one cycle behind lookup_index
    tag_t  tag_q;
    line_t line_q;
    logic  valid_q;

    // tag and line rams
    // the read port runs every cycle, the controller only looks at it in LOOKUP
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            line_mem[wr_index] <= wr_line;
        end
        tag_q  <= tag_mem[lookup_index];
        line_q <= line_mem[lookup_index];
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (inv_all) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (inv_all) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid[lookup_index];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare
    ////////////////////////////////////////////////////////////////////////////

    // compare_tag comes from the buffered request,
    // which lines up with the data read on the accepting edge
    always_comb begin
        lookup.hit  = valid_q && (tag_q == compare_tag);
        lookup.line = line_q;
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_icache

if ! ./obj_dir/Vtb_icache > sim.log 2>&1; then
    echo "simulator exited with an error status" >> sim.log
fi
cat sim.log

if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;
    import icache_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    fetch_req_t  fetch_req;
    logic        fetch_ready;
    logic        resp_valid;
    fetch_resp_t resp;
    logic        resp_ready;
    logic        flush;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_data_valid;
    line_t       mem_data;

    int   value_errors = 0;
    int   other_errors = 0;
    int   cycle_count  = 0;
    // about 20 fetches at under 15 cycles each even with the longest delay
    int   cycle_limit  = 4000;
    logic end_reported = 1'b0;

    icache_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_valid    (fetch_valid),
        .fetch_req      (fetch_req),
        .fetch_ready    (fetch_ready),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .resp_ready     (resp_ready),
        .flush          (flush),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data)
    );

    icache_mem_model mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            end_reported = 1'b1;
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // run stopped before the summary by an assertion
    final begin
        if (!end_reported) begin
            $display("CHECKS FAILED");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic instr_t expected_word(addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic note_failure(input string what);
        $display("error at %0t: %s", $time, what);
        other_errors++;
    endtask

    // returns on the edge that accepts the request
    task automatic send_fetch(input addr_t a);
        @(posedge clk);
        fetch_valid    <= 1'b1;
        fetch_req.addr <= a;
        @(negedge clk);
        while (!fetch_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    // edges from acceptance until resp_valid shows
    task automatic wait_response(output int edges);
        edges = 0;
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
            edges++;
        end
    endtask

    // an even word brings its neighbour and an odd word stands alone
    task automatic check_response(input addr_t a);
        instr_t exp1;
        logic   exp_second;
        exp_second = !a[2];
        exp1       = exp_second ? expected_word(a + 4) : '0;
        if (resp.pc !== a) report_mismatch("resp.pc", resp.pc, a);
        if (resp.instr0 !== expected_word(a)) begin
            report_mismatch("resp.instr0", resp.instr0, expected_word(a));
        end
        if (resp.instr1 !== exp1) report_mismatch("resp.instr1", resp.instr1, exp1);
        if (resp.second_valid !== exp_second) begin
            report_mismatch("resp.second_valid", 32'(resp.second_valid), 32'(exp_second));
        end
    endtask

    task automatic fetch_round(input addr_t a, input logic expect_hit);
        int    edges;
        int    count_before;
        addr_t line_addr;
        count_before = mem.req_count;
        line_addr    = {a[31:4], 4'h0};
        send_fetch(a);
        wait_response(edges);
        check_response(a);
        if (expect_hit) begin
            if (edges != 1) note_failure($sformatf("hit at %h took %0d cycles", a, edges));
            if (mem.req_count != count_before) begin
                note_failure($sformatf("hit at %h went to memory", a));
            end
        end else if (mem.req_count != count_before + 1) begin
            note_failure($sformatf("miss at %h did not make exactly one request", a));
        end else if (mem.last_line_addr !== line_addr) begin
            report_mismatch("mem_req.line_addr", mem.last_line_addr, line_addr);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic after_reset;
        @(negedge clk);
        if (resp_valid !== 1'b0) report_mismatch("resp_valid", 32'(resp_valid), 32'h0);
        if (mem_req_valid !== 1'b0) report_mismatch("mem_req_valid", 32'(mem_req_valid), 32'h0);
        if (fetch_ready !== 1'b1) report_mismatch("fetch_ready", 32'(fetch_ready), 32'h1);
    endtask

    task automatic miss_then_hit;
        fetch_round(32'h0000_1040, 1'b0);
        fetch_round(32'h0000_1048, 1'b1);
    endtask

    task automatic word_pair_rule;
        fetch_round(32'h0000_1044, 1'b1);
        fetch_round(32'h0000_104c, 1'b1);
        // odd word straight from a refill
        fetch_round(32'h0000_2054, 1'b0);
    endtask

    // set 6 with three different tags
    task automatic lru_same_set;
        int start;
        start = mem.req_count;
        fetch_round(32'h0001_0060, 1'b0);
        fetch_round(32'h0002_0060, 1'b0);
        fetch_round(32'h0001_0064, 1'b1);
        fetch_round(32'h0003_0068, 1'b0);
        if (mem.req_count != start + 3) begin
            note_failure($sformatf("%0d memory requests after C", mem.req_count - start));
        end
        fetch_round(32'h0001_0060, 1'b1);
        fetch_round(32'h0002_006c, 1'b0);
    endtask

    task automatic flush_refetch;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        fetch_round(32'h0000_1040, 1'b0);
        fetch_round(32'h0001_0060, 1'b0);
    endtask

    task automatic back_pressure;
        fetch_resp_t held;
        int          edges;
        @(posedge clk);
        resp_ready <= 1'b0;
        send_fetch(32'h0000_1048);
        wait_response(edges);
        if (edges != 1) note_failure($sformatf("stalled hit took %0d cycles", edges));
        held = resp;
        check_response(32'h0000_1048);
        repeat (5) begin
            @(negedge clk);
            if (resp_valid !== 1'b1) report_mismatch("resp_valid", 32'(resp_valid), 32'h1);
            if (fetch_ready !== 1'b0) report_mismatch("fetch_ready", 32'(fetch_ready), 32'h0);
            if (resp !== held) note_failure("resp changed while resp_ready was low");
        end
        @(posedge clk);
        resp_ready <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (resp_valid !== 1'b0) note_failure("response not taken after resp_ready rose");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       <= 1'b0;
        fetch_valid <= 1'b0;
        fetch_req   <= '0;
        resp_ready  <= 1'b1;
        flush       <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        after_reset();
        miss_then_hit();
        word_pair_rule();
        lru_same_set();
        flush_refetch();
        back_pressure();

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        end_reported = 1'b1;
        if (value_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
